// ==== Bender.yml ====
package:
  name: periph_soc

sources:
  - common/soc_pkg.sv
  - common/axi4lite_if.sv
  - verilog/axil_xbar.sv
  - verilog/axil_sram.sv
  - verilog/axil_gpio.sv
  - verilog/periph_soc.sv
  - target: test
    files:
      - tests/periph_soc_tb.sv

// ==== common/axi4lite_if.sv ====
`timescale 1ns/1ps

interface axi4lite_if;

    soc_pkg::addr_t awaddr;
    logic           awvalid;
    logic           awready;

    soc_pkg::data_t wdata;
    soc_pkg::strb_t wstrb;
    logic           wvalid;
    logic           wready;

    soc_pkg::resp_t bresp;
    logic           bvalid;
    logic           bready;

    soc_pkg::addr_t araddr;
    logic           arvalid;
    logic           arready;

    soc_pkg::data_t rdata;
    soc_pkg::resp_t rresp;
    logic           rvalid;
    logic           rready;

    modport master (
        output awaddr, awvalid,
        input  awready,
        output wdata, wstrb, wvalid,
        input  wready,
        input  bresp, bvalid,
        output bready,
        output araddr, arvalid,
        input  arready,
        input  rdata, rresp, rvalid,
        output rready
    );

    modport slave (
        input  awaddr, awvalid,
        output awready,
        input  wdata, wstrb, wvalid,
        output wready,
        output bresp, bvalid,
        input  bready,
        input  araddr, arvalid,
        output arready,
        output rdata, rresp, rvalid,
        input  rready
    );

endinterface

// ==== common/soc_pkg.sv ====
package soc_pkg;

    // Bus widths
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [1:0]  resp_t;

    // Top nibble of the address picks the device
    typedef logic [3:0]  region_t;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    localparam region_t REGION_SRAM = 4'h1;
    localparam region_t REGION_GPIO = 4'h2;

    // GPIO registers, only bit 3 tells them apart
    localparam addr_t GPIO_OUT_OFFSET = 32'd0;
    localparam addr_t GPIO_IN_OFFSET  = 32'd8;

endpackage

// ==== tests/periph_soc_tb.sv ====
`timescale 1ns/1ps

module periph_soc_tb;

    localparam int CLK_PERIOD = 40;
    localparam int SAMPLE_DLY = CLK_PERIOD / 4;
    localparam int SRAM_BYTES = 8 * 1024;
    localparam int GPIO_WIDTH = 8;
    localparam int POOL       = 32;
    localparam int N_FULL     = 40;
    localparam int N_STRB     = 40;
    localparam int N_GPIO     = 12;
    localparam int N_DEC      = 12;
    localparam int N_RAND     = 300;
    // Bus transactions over all tests
    localparam int N_TXN = 2 * N_FULL + POOL + 2 * N_STRB + 1 + 3 * N_GPIO + 4 * N_DEC + N_RAND;

    logic clk, rst;
    logic [GPIO_WIDTH-1:0] gpio_out, gpio_in;
    soc_pkg::addr_t s_axil_awaddr, s_axil_araddr;
    soc_pkg::data_t s_axil_wdata, s_axil_rdata;
    soc_pkg::strb_t s_axil_wstrb;
    soc_pkg::resp_t s_axil_bresp, s_axil_rresp;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic s_axil_rvalid, s_axil_rready;

    // Reference model state
    soc_pkg::data_t        sram_model [int];
    logic [GPIO_WIDTH-1:0] gpio_out_model;
    logic [GPIO_WIDTH-1:0] gpio_in_model;

    periph_soc dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "Run stopped at the first error");
    endtask

    initial begin
        repeat (N_TXN * 40 + 1000) @(posedge clk);
        fail_run("Timeout: the tests did not finish in the expected time");
    end

    function automatic soc_pkg::data_t rand_data();
        return {$urandom(), $urandom()};
    endfunction

    // Word idx of the SRAM seen through a random mirror of the region
    function automatic soc_pkg::addr_t sram_addr(input int idx);
        int unsigned mirror;
        mirror = $urandom_range(2**28 / SRAM_BYTES - 1);
        return {soc_pkg::REGION_SRAM, 28'(mirror * SRAM_BYTES + idx * 8)};
    endfunction

    function automatic soc_pkg::addr_t gpio_addr(input bit in_reg);
        soc_pkg::addr_t off;
        off = in_reg ? soc_pkg::GPIO_IN_OFFSET : soc_pkg::GPIO_OUT_OFFSET;
        return {soc_pkg::REGION_GPIO, 28'($urandom() & 32'h0FFF_FFF0)} | off;
    endfunction

    function automatic soc_pkg::addr_t unmapped_addr();
        logic [3:0] region;
        do
            region = 4'($urandom_range(15));
        while (region == soc_pkg::REGION_SRAM || region == soc_pkg::REGION_GPIO);
        return {region, 28'($urandom() & 32'h0FFF_FFF8)};
    endfunction

    function automatic int word_index(input soc_pkg::addr_t addr);
        return (int'(addr[27:0]) % SRAM_BYTES) / 8;
    endfunction

    function automatic soc_pkg::resp_t model_write(input soc_pkg::addr_t addr,
                                                   input soc_pkg::data_t data,
                                                   input soc_pkg::strb_t strb);
        soc_pkg::data_t word;
        int idx;
        if (addr[31:28] == soc_pkg::REGION_SRAM) begin
            idx = word_index(addr);
            word = sram_model.exists(idx) ? sram_model[idx] : '0;
            for (int i = 0; i < 8; i++) begin
                if (strb[i])
                    word[i*8 +: 8] = data[i*8 +: 8];
            end
            sram_model[idx] = word;
            return soc_pkg::RESP_OKAY;
        end
        if (addr[31:28] == soc_pkg::REGION_GPIO) begin
            if (addr[3] == soc_pkg::GPIO_OUT_OFFSET[3] && strb[0])
                gpio_out_model = data[GPIO_WIDTH-1:0];
            return soc_pkg::RESP_OKAY;
        end
        return soc_pkg::RESP_DECERR;
    endfunction

    task automatic model_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                              output soc_pkg::resp_t resp, output bit known);
        data  = '0;
        resp  = soc_pkg::RESP_OKAY;
        known = 1'b1;
        if (addr[31:28] == soc_pkg::REGION_SRAM) begin
            known = sram_model.exists(word_index(addr));
            if (known)
                data = sram_model[word_index(addr)];
        end else if (addr[31:28] == soc_pkg::REGION_GPIO) begin
            if (addr[3] == soc_pkg::GPIO_IN_OFFSET[3])
                data = soc_pkg::data_t'(gpio_in_model);
            else
                data = soc_pkg::data_t'(gpio_out_model);
        end else begin
            resp = soc_pkg::RESP_DECERR;
        end
    endtask

    task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                             input soc_pkg::strb_t strb, output soc_pkg::resp_t resp,
                             output logic [GPIO_WIDTH-1:0] out_at_b);
        int aw_at, w_at, hold, cyc;
        bit aw_done, w_done;
        aw_at = 0;
        w_at  = 0;
        if ($urandom_range(1))
            aw_at = $urandom_range(2);
        else
            w_at = $urandom_range(2);
        hold    = $urandom_range(3);
        aw_done = 1'b0;
        w_done  = 1'b0;
        cyc     = 0;
        while (!(aw_done && w_done)) begin
            @(negedge clk);
            s_axil_awaddr  = addr;
            s_axil_wdata   = data;
            s_axil_wstrb   = strb;
            s_axil_awvalid = !aw_done && cyc >= aw_at;
            s_axil_wvalid  = !w_done && cyc >= w_at;
            #(SAMPLE_DLY);
            assert (!s_axil_bvalid) else
                fail_run($sformatf("Write response for 0x%08h came before AW and W", addr));
            if (s_axil_awvalid && s_axil_awready)
                aw_done = 1'b1;
            if (s_axil_wvalid && s_axil_wready)
                w_done = 1'b1;
            cyc++;
        end
        // Back-pressure counts cycles with bvalid already up
        cyc = 0;
        do begin
            @(negedge clk);
            s_axil_awvalid = 1'b0;
            s_axil_wvalid  = 1'b0;
            s_axil_bready  = cyc >= hold;
            #(SAMPLE_DLY);
            assert (cyc == 0 || s_axil_bvalid) else
                fail_run($sformatf("Write response for 0x%08h dropped before bready", addr));
            if (s_axil_bvalid && cyc == 0)
                out_at_b = gpio_out;
            if (s_axil_bvalid)
                cyc++;
        end while (!(s_axil_bvalid && s_axil_bready));
        resp = s_axil_bresp;
        @(negedge clk);
        s_axil_bready = 1'b0;
    endtask

    task automatic bus_read(input soc_pkg::addr_t addr, output soc_pkg::data_t data,
                            output soc_pkg::resp_t resp);
        int hold, cyc;
        bit ar_done;
        hold    = $urandom_range(3);
        ar_done = 1'b0;
        while (!ar_done) begin
            @(negedge clk);
            s_axil_araddr  = addr;
            s_axil_arvalid = 1'b1;
            #(SAMPLE_DLY);
            assert (!s_axil_rvalid) else
                fail_run($sformatf("Read response for 0x%08h came before AR", addr));
            ar_done = s_axil_arready;
        end
        cyc = 0;
        do begin
            @(negedge clk);
            s_axil_arvalid = 1'b0;
            s_axil_rready  = cyc >= hold;
            #(SAMPLE_DLY);
            assert (cyc == 0 || s_axil_rvalid) else
                fail_run($sformatf("Read response for 0x%08h dropped before rready", addr));
            if (s_axil_rvalid)
                cyc++;
        end while (!(s_axil_rvalid && s_axil_rready));
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(negedge clk);
        s_axil_rready = 1'b0;
    endtask

    task automatic do_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
                            input soc_pkg::strb_t strb);
        soc_pkg::resp_t resp, exp_resp;
        logic [GPIO_WIDTH-1:0] out_at_b;
        bus_write(addr, data, strb, resp, out_at_b);
        exp_resp = model_write(addr, data, strb);
        assert (resp == exp_resp) else
            fail_run($sformatf("MISMATCH at %0t: write 0x%08h resp %0d, expected %0d",
                               $time, addr, resp, exp_resp));
        assert (out_at_b == gpio_out_model) else
            fail_run($sformatf(
                "MISMATCH at %0t: gpio_out 0x%0h after write 0x%08h, expected 0x%0h",
                $time, out_at_b, addr, gpio_out_model));
    endtask

    task automatic do_read(input soc_pkg::addr_t addr);
        soc_pkg::data_t got, exp_data;
        soc_pkg::resp_t got_resp, exp_resp;
        bit known;
        bus_read(addr, got, got_resp);
        model_read(addr, exp_data, exp_resp, known);
        assert (got_resp == exp_resp && (!known || got == exp_data)) else
            fail_run($sformatf(
                "MISMATCH at %0t: read 0x%08h got 0x%016h/%0d, expected 0x%016h/%0d",
                $time, addr, got, got_resp, exp_data, exp_resp));
    endtask

    task automatic drive_gpio_in(input logic [GPIO_WIDTH-1:0] value);
        @(negedge clk);
        gpio_in       = value;
        gpio_in_model = value;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int idx;
        soc_pkg::addr_t addr;
        void'($urandom(32'he010));
        rst = 1'b1;
        gpio_in = '0;
        s_axil_awaddr = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b0;
        s_axil_araddr = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b0;
        gpio_in_model = '0;
        gpio_out_model = '0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        #(SAMPLE_DLY);
        assert (gpio_out == '0 && !s_axil_bvalid && !s_axil_rvalid && !s_axil_awready &&
                !s_axil_wready && !s_axil_arready) else
            fail_run("Outputs were not cleared by reset");

        // Full words, read back through another mirror
        for (int i = 0; i < N_FULL; i++) begin
            idx = $urandom_range(SRAM_BYTES / 8 - 1);
            do_write(sram_addr(idx), rand_data(), 8'hFF);
            do_read(sram_addr(idx));
        end

        // Byte strobes on a small pool of known words
        for (int i = 0; i < POOL; i++)
            do_write(sram_addr(i), rand_data(), 8'hFF);
        for (int i = 0; i < N_STRB; i++) begin
            idx = $urandom_range(POOL - 1);
            do_write(sram_addr(idx), rand_data(), 8'($urandom()));
            do_read(sram_addr(idx));
        end

        // GPIO output register
        do_read(gpio_addr(1'b0));
        for (int i = 0; i < N_GPIO; i++) begin
            do_write(gpio_addr(1'($urandom_range(1))), rand_data(), 8'($urandom()));
            do_read(gpio_addr(1'b0));
        end

        // GPIO input through the synchronizer
        for (int i = 0; i < N_GPIO; i++) begin
            drive_gpio_in(GPIO_WIDTH'($urandom()));
            do_read(gpio_addr(1'b1));
        end

        // Unmapped writes carry the offset of a known SRAM word, then confirm nothing moved
        for (int i = 0; i < N_DEC; i++) begin
            idx = $urandom_range(POOL - 1);
            addr = (unmapped_addr() & 32'hF000_0000) | (sram_addr(idx) & 32'h0FFF_FFFF);
            do_write(addr, rand_data(), 8'($urandom()));
            do_read(unmapped_addr());
            do_read(sram_addr(idx));
            do_read(gpio_addr(1'b0));
        end

        // Mixed traffic over all regions
        for (int i = 0; i < N_RAND; i++) begin
            case ($urandom_range(6))
                0: do_write(sram_addr($urandom_range(POOL - 1)), rand_data(), 8'($urandom()));
                1, 2: do_read(sram_addr($urandom_range(POOL - 1)));
                3: do_write(gpio_addr(1'($urandom_range(1))), rand_data(), 8'($urandom()));
                4: do_read(gpio_addr(1'($urandom_range(1))));
                5: begin
                    if ($urandom_range(1))
                        do_write(unmapped_addr(), rand_data(), 8'($urandom()));
                    else
                        do_read(unmapped_addr());
                end
                default: drive_gpio_in(GPIO_WIDTH'($urandom()));
            endcase
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== verilog/axil_gpio.sv ====
`timescale 1ns/1ps

module axil_gpio #(
    parameter int GPIO_WIDTH = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    axi4lite_if.slave             bus,
    output logic [GPIO_WIDTH-1:0] gpio_out,
    input  logic [GPIO_WIDTH-1:0] gpio_in
);

    logic [GPIO_WIDTH-1:0] in_meta, in_sync;
    logic wr_en, rd_en;
    logic wr_out, rd_in;

    assign wr_en = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign rd_en = bus.arvalid && !bus.rvalid;

    assign bus.awready = wr_en;
    assign bus.wready  = wr_en;
    assign bus.arready = rd_en;
    assign bus.bresp   = soc_pkg::RESP_OKAY;
    assign bus.rresp   = soc_pkg::RESP_OKAY;

    // Register select, the rest of the region mirrors
    assign wr_out = bus.awaddr[3] == soc_pkg::GPIO_OUT_OFFSET[3];
    assign rd_in  = bus.araddr[3] == soc_pkg::GPIO_IN_OFFSET[3];

    // Two-flop synchronizer on the pins
    always_ff @(posedge clk) begin
        in_meta <= gpio_in;
        in_sync <= in_meta;
    end

    always_ff @(posedge clk) begin
        if (rd_en)
            bus.rdata <= rd_in ? soc_pkg::data_t'(in_sync) : soc_pkg::data_t'(gpio_out);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gpio_out   <= '0;
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            // Input register is read-only, writes there just get OKAY
            if (wr_en && wr_out && bus.wstrb[0])
                gpio_out <= bus.wdata[GPIO_WIDTH-1:0];

            if (wr_en)
                bus.bvalid <= 1'b1;
            else if (bus.bready)
                bus.bvalid <= 1'b0;

            if (rd_en)
                bus.rvalid <= 1'b1;
            else if (bus.rready)
                bus.rvalid <= 1'b0;
        end
    end

endmodule

// ==== verilog/axil_sram.sv ====
`timescale 1ns/1ps

module axil_sram #(
    parameter int SRAM_SIZE_KB = 8
) (
    input  logic      clk,
    input  logic      rst,
    axi4lite_if.slave bus
);

    localparam int BYTES = $bits(soc_pkg::strb_t);
    localparam int WORDS = SRAM_SIZE_KB * 1024 / BYTES;
    localparam int IDX_W = $clog2(WORDS);

    typedef logic [IDX_W-1:0] idx_t;

    soc_pkg::data_t mem [WORDS];

    idx_t wr_idx, rd_idx;
    logic wr_en, rd_en;

    // Word index, upper address bits wrap
    assign wr_idx = bus.awaddr[IDX_W+2:3];
    assign rd_idx = bus.araddr[IDX_W+2:3];

    // AW and W go in together, one outstanding response per path
    assign wr_en = bus.awvalid && bus.wvalid && !bus.bvalid;
    assign rd_en = bus.arvalid && !bus.rvalid;

    assign bus.awready = wr_en;
    assign bus.wready  = wr_en;
    assign bus.arready = rd_en;
    assign bus.bresp   = soc_pkg::RESP_OKAY;
    assign bus.rresp   = soc_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < BYTES; i++) begin
                if (bus.wstrb[i])
                    mem[wr_idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
            end
        end
        if (rd_en)
            bus.rdata <= mem[rd_idx];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bus.bvalid <= 1'b0;
            bus.rvalid <= 1'b0;
        end else begin
            if (wr_en)
                bus.bvalid <= 1'b1;
            else if (bus.bready)
                bus.bvalid <= 1'b0;

            if (rd_en)
                bus.rvalid <= 1'b1;
            else if (bus.rready)
                bus.rvalid <= 1'b0;
        end
    end

endmodule

// ==== verilog/axil_xbar.sv ====
`timescale 1ns/1ps

module axil_xbar (
    input  logic       clk,
    input  logic       rst,
    axi4lite_if.slave  host,
    axi4lite_if.master sram,
    axi4lite_if.master gpio
);

    typedef enum logic [1:0] {TGT_NONE, TGT_SRAM, TGT_GPIO} tgt_e;
    typedef enum logic [1:0] {W_IDLE, W_REQ, W_WAIT, W_RESP} wr_state_e;
    typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_RESP} rd_state_e;

    wr_state_e wr_state;
    rd_state_e rd_state;
    tgt_e      wr_tgt, rd_tgt;
    tgt_e      aw_tgt, ar_tgt;

    soc_pkg::addr_t wr_addr, rd_addr;
    soc_pkg::data_t wr_data, rd_data;
    soc_pkg::strb_t wr_strb;
    soc_pkg::resp_t wr_resp, rd_resp;

    // W accepted from host, AW and W still owed to the slave
    logic have_w, aw_pend, w_pend;
    logic aw_fire, w_fire, ar_fire;
    logic wr_issue, sub_aw_fire, sub_w_fire;

    // Channels of whichever slave the path targets
    logic           sel_awready, sel_wready, sel_bvalid, sel_arready, sel_rvalid;
    soc_pkg::resp_t sel_bresp, sel_rresp;
    soc_pkg::data_t sel_rdata;

    function automatic tgt_e decode(input soc_pkg::addr_t addr);
        case (addr[31:28])
            soc_pkg::REGION_SRAM: return TGT_SRAM;
            soc_pkg::REGION_GPIO: return TGT_GPIO;
            default:              return TGT_NONE;
        endcase
    endfunction

    assign aw_tgt = decode(host.awaddr);
    assign ar_tgt = decode(host.araddr);

    // W is never taken ahead of its AW
    assign host.awready = (wr_state == W_IDLE) && host.awvalid;
    assign host.wready  = ((wr_state == W_IDLE) && host.awvalid && host.wvalid) ||
                          ((wr_state == W_REQ) && !have_w && host.wvalid);
    assign host.bvalid  = (wr_state == W_RESP);
    assign host.bresp   = wr_resp;
    assign host.arready = (rd_state == R_IDLE) && host.arvalid;
    assign host.rvalid  = (rd_state == R_RESP);
    assign host.rdata   = rd_data;
    assign host.rresp   = rd_resp;

    assign aw_fire = host.awvalid && host.awready;
    assign w_fire  = host.wvalid && host.wready;
    assign ar_fire = host.arvalid && host.arready;

    assign wr_issue    = (wr_state == W_REQ) && have_w;
    assign sub_aw_fire = wr_issue && aw_pend && sel_awready;
    assign sub_w_fire  = wr_issue && w_pend && sel_wready;

    assign sram.awaddr  = wr_addr;
    assign sram.awvalid = wr_issue && aw_pend && (wr_tgt == TGT_SRAM);
    assign sram.wdata   = wr_data;
    assign sram.wstrb   = wr_strb;
    assign sram.wvalid  = wr_issue && w_pend && (wr_tgt == TGT_SRAM);
    assign sram.bready  = (wr_state == W_WAIT) && (wr_tgt == TGT_SRAM);
    assign sram.araddr  = rd_addr;
    assign sram.arvalid = (rd_state == R_REQ) && (rd_tgt == TGT_SRAM);
    assign sram.rready  = (rd_state == R_WAIT) && (rd_tgt == TGT_SRAM);

    assign gpio.awaddr  = wr_addr;
    assign gpio.awvalid = wr_issue && aw_pend && (wr_tgt == TGT_GPIO);
    assign gpio.wdata   = wr_data;
    assign gpio.wstrb   = wr_strb;
    assign gpio.wvalid  = wr_issue && w_pend && (wr_tgt == TGT_GPIO);
    assign gpio.bready  = (wr_state == W_WAIT) && (wr_tgt == TGT_GPIO);
    assign gpio.araddr  = rd_addr;
    assign gpio.arvalid = (rd_state == R_REQ) && (rd_tgt == TGT_GPIO);
    assign gpio.rready  = (rd_state == R_WAIT) && (rd_tgt == TGT_GPIO);

    always_comb begin
        sel_awready = 1'b0;
        sel_wready  = 1'b0;
        sel_bvalid  = 1'b0;
        sel_bresp   = soc_pkg::RESP_OKAY;
        sel_arready = 1'b0;
        sel_rvalid  = 1'b0;
        sel_rdata   = '0;
        sel_rresp   = soc_pkg::RESP_OKAY;
        case (wr_tgt)
            TGT_SRAM: begin
                sel_awready = sram.awready;
                sel_wready  = sram.wready;
                sel_bvalid  = sram.bvalid;
                sel_bresp   = sram.bresp;
            end
            TGT_GPIO: begin
                sel_awready = gpio.awready;
                sel_wready  = gpio.wready;
                sel_bvalid  = gpio.bvalid;
                sel_bresp   = gpio.bresp;
            end
            default: ;
        endcase
        case (rd_tgt)
            TGT_SRAM: begin
                sel_arready = sram.arready;
                sel_rvalid  = sram.rvalid;
                sel_rdata   = sram.rdata;
                sel_rresp   = sram.rresp;
            end
            TGT_GPIO: begin
                sel_arready = gpio.arready;
                sel_rvalid  = gpio.rvalid;
                sel_rdata   = gpio.rdata;
                sel_rresp   = gpio.rresp;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= W_IDLE;
            wr_tgt   <= TGT_NONE;
            have_w   <= 1'b0;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
        end else begin
            case (wr_state)
                W_IDLE: begin
                    if (aw_fire) begin
                        wr_tgt   <= aw_tgt;
                        have_w   <= w_fire;
                        aw_pend  <= 1'b1;
                        w_pend   <= 1'b1;
                        wr_state <= (w_fire && aw_tgt == TGT_NONE) ? W_RESP : W_REQ;
                    end
                end
                W_REQ: begin
                    if (sub_aw_fire)
                        aw_pend <= 1'b0;
                    if (sub_w_fire)
                        w_pend <= 1'b0;
                    if (w_fire) begin
                        have_w <= 1'b1;
                        if (wr_tgt == TGT_NONE)
                            wr_state <= W_RESP;
                    end
                    if ((!aw_pend || sub_aw_fire) && (!w_pend || sub_w_fire))
                        wr_state <= W_WAIT;
                end
                W_WAIT: begin
                    if (sel_bvalid)
                        wr_state <= W_RESP;
                end
                W_RESP: begin
                    if (host.bready)
                        wr_state <= W_IDLE;
                end
                default: wr_state <= W_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= R_IDLE;
            rd_tgt   <= TGT_NONE;
        end else begin
            case (rd_state)
                R_IDLE: begin
                    if (ar_fire) begin
                        rd_tgt   <= ar_tgt;
                        rd_state <= (ar_tgt == TGT_NONE) ? R_RESP : R_REQ;
                    end
                end
                R_REQ: begin
                    if (sel_arready)
                        rd_state <= R_WAIT;
                end
                R_WAIT: begin
                    if (sel_rvalid)
                        rd_state <= R_RESP;
                end
                R_RESP: begin
                    if (host.rready)
                        rd_state <= R_IDLE;
                end
                default: rd_state <= R_IDLE;
            endcase
        end
    end

    // Responses start as DECERR and get replaced by the slave's answer
    always_ff @(posedge clk) begin
        if (aw_fire)
            wr_addr <= host.awaddr;
        if (w_fire) begin
            wr_data <= host.wdata;
            wr_strb <= host.wstrb;
            wr_resp <= soc_pkg::RESP_DECERR;
        end else if (wr_state == W_WAIT && sel_bvalid) begin
            wr_resp <= sel_bresp;
        end
        if (ar_fire) begin
            rd_addr <= host.araddr;
            rd_data <= '0;
            rd_resp <= soc_pkg::RESP_DECERR;
        end else if (rd_state == R_WAIT && sel_rvalid) begin
            rd_data <= sel_rdata;
            rd_resp <= sel_rresp;
        end
    end

endmodule

// ==== verilog/periph_soc.sv ====
`timescale 1ns/1ps

module periph_soc #(
    parameter int SRAM_SIZE_KB = 8,
    parameter int GPIO_WIDTH   = 8
) (
    input  logic                  clk,
    input  logic                  rst,

    output logic [GPIO_WIDTH-1:0] gpio_out,
    input  logic [GPIO_WIDTH-1:0] gpio_in,

    // Host AXI4-lite
    input  soc_pkg::addr_t        s_axil_awaddr,
    input  logic                  s_axil_awvalid,
    output logic                  s_axil_awready,

    input  soc_pkg::data_t        s_axil_wdata,
    input  soc_pkg::strb_t        s_axil_wstrb,
    input  logic                  s_axil_wvalid,
    output logic                  s_axil_wready,

    output soc_pkg::resp_t        s_axil_bresp,
    output logic                  s_axil_bvalid,
    input  logic                  s_axil_bready,

    input  soc_pkg::addr_t        s_axil_araddr,
    input  logic                  s_axil_arvalid,
    output logic                  s_axil_arready,

    output soc_pkg::data_t        s_axil_rdata,
    output soc_pkg::resp_t        s_axil_rresp,
    output logic                  s_axil_rvalid,
    input  logic                  s_axil_rready
);

    axi4lite_if host_bus();
    axi4lite_if sram_bus();
    axi4lite_if gpio_bus();

    assign host_bus.awaddr  = s_axil_awaddr;
    assign host_bus.awvalid = s_axil_awvalid;
    assign s_axil_awready   = host_bus.awready;

    assign host_bus.wdata   = s_axil_wdata;
    assign host_bus.wstrb   = s_axil_wstrb;
    assign host_bus.wvalid  = s_axil_wvalid;
    assign s_axil_wready    = host_bus.wready;

    assign s_axil_bresp     = host_bus.bresp;
    assign s_axil_bvalid    = host_bus.bvalid;
    assign host_bus.bready  = s_axil_bready;

    assign host_bus.araddr  = s_axil_araddr;
    assign host_bus.arvalid = s_axil_arvalid;
    assign s_axil_arready   = host_bus.arready;

    assign s_axil_rdata     = host_bus.rdata;
    assign s_axil_rresp     = host_bus.rresp;
    assign s_axil_rvalid    = host_bus.rvalid;
    assign host_bus.rready  = s_axil_rready;

    axil_xbar xbar_i (
        .clk,
        .rst,
        .host (host_bus),
        .sram (sram_bus),
        .gpio (gpio_bus)
    );

    // Region 0x1
    axil_sram #(
        .SRAM_SIZE_KB(SRAM_SIZE_KB)
    ) sram_i (
        .clk,
        .rst,
        .bus (sram_bus)
    );

    // Region 0x2
    axil_gpio #(
        .GPIO_WIDTH(GPIO_WIDTH)
    ) gpio_i (
        .clk,
        .rst,
        .bus      (gpio_bus),
        .gpio_out,
        .gpio_in
    );

endmodule

// ==== vlog.f ====
common/soc_pkg.sv
common/axi4lite_if.sv
verilog/axil_xbar.sv
verilog/axil_sram.sv
verilog/axil_gpio.sv
verilog/periph_soc.sv
tests/periph_soc_tb.sv
